// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = dataMemoryTb
FILELIST = verilog.f
BUILDDIR = obj_dir
LOG      = sim.log
FAILMSG  = tests failed
PASSMSG  = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG) || ! grep -q "$(PASSMSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== hdl/addressDecoder.sv ====
`timescale 1ns/1ps

module addressDecoder (
    input  logic                writeEnable,
    input  memMapPkg::addrT     address,
    input  memMapPkg::wordT     writeData,
    bankPortIf.decoder          banks [memMapPkg::numBanks],
    output logic                ledWrite,
    output logic                tubeWrite,
    output memMapPkg::regionT   region,
    output memMapPkg::bankSelT  bankSel
);

    memMapPkg::wordIndexT wordIndex;
    logic                 isLed;
    logic                 isTube;
    logic                 ramWrite;
    logic [memMapPkg::numBanks-1:0] bankStrobes;

    assign wordIndex = address[9:2];
    assign bankSel   = wordIndex[7:6];

    assign isLed  = (address == memMapPkg::ledAddr);
    assign isTube = (address == memMapPkg::tubeAddr);

    assign ledWrite  = writeEnable && isLed;
    assign tubeWrite = writeEnable && isTube;

    // Every other write lands in RAM even inside the table window
    assign ramWrite = writeEnable && !isLed && !isTube;

    for (genvar g = 0; g < memMapPkg::numBanks; g++) begin : genBankPorts
        assign bankStrobes[g]       = ramWrite && (bankSel == memMapPkg::bankSelT'(g));
        assign banks[g].writeStrobe = bankStrobes[g];
        assign banks[g].offset      = wordIndex[5:0];
        assign banks[g].writeData   = writeData;
    end

    // Read side classification
    always_comb begin
        if (address == memMapPkg::switchAddr) begin
            region = memMapPkg::regionSwitch;
        end else if (address >= memMapPkg::tableBase && address <= memMapPkg::tableLast) begin
            region = memMapPkg::regionTable;
        end else begin
            region = memMapPkg::regionRam;
        end
    end

endmodule

// ==== hdl/bankPortIf.sv ====
`timescale 1ns/1ps

interface bankPortIf;

    logic                  writeStrobe;
    memMapPkg::bankOffsetT offset;
    memMapPkg::wordT       writeData;
    memMapPkg::wordT       readWord;

    // Decoder drives the request side
    modport decoder (
        output writeStrobe,
        output offset,
        output writeData
    );

    modport bank (
        input  writeStrobe,
        input  offset,
        input  writeData,
        output readWord
    );

    // Read multiplexer only needs the data
    modport reader (
        input readWord
    );

endinterface

// ==== hdl/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory (
    input  logic             Uart_send_trigger,
    input  logic             clk,
    input  logic             readEnable,
    input  logic             writeEnable,
    input  memMapPkg::addrT  address,
    input  memMapPkg::wordT  writeData,
    input  memMapPkg::ledT   switches,
    output memMapPkg::ledT   led,
    output memMapPkg::tubeT  tube,
    output memMapPkg::wordT  readData
);

    memMapPkg::regionT    region;
    memMapPkg::bankSelT   bankSel;
    memMapPkg::wordIndexT tableIndex;
    memMapPkg::segT       hundreds;
    memMapPkg::segT       tens;
    memMapPkg::segT       ones;
    logic                 ledWrite;
    logic                 tubeWrite;

    bankPortIf bankBus [memMapPkg::numBanks] ();

    // Table index is the word index of the window address
    assign tableIndex = address[9:2];

    addressDecoder addressDecoder_i (
        .writeEnable (writeEnable),
        .address     (address),
        .writeData   (writeData),
        .banks       (bankBus),
        .ledWrite    (ledWrite),
        .tubeWrite   (tubeWrite),
        .region      (region),
        .bankSel     (bankSel)
    );

    for (genvar g = 0; g < memMapPkg::numBanks; g++) begin : genBanks
        memoryBank memoryBank_i (
            .Uart_send_trigger (Uart_send_trigger),
            .clk               (clk),
            .bankPort          (bankBus[g])
        );
    end

    outputRegs outputRegs_i (
        .Uart_send_trigger (Uart_send_trigger),
        .clk               (clk),
        .ledWrite          (ledWrite),
        .tubeWrite         (tubeWrite),
        .writeData         (writeData),
        .led               (led),
        .tube              (tube)
    );

    segmentTable segmentTable_i (
        .index    (tableIndex),
        .hundreds (hundreds),
        .tens     (tens),
        .ones     (ones)
    );

    readMux readMux_i (
        .readEnable (readEnable),
        .region     (region),
        .bankSel    (bankSel),
        .banks      (bankBus),
        .switches   (switches),
        .hundreds   (hundreds),
        .tens       (tens),
        .ones       (ones),
        .readData   (readData)
    );

endmodule

// ==== hdl/memMapPkg.sv ====
package memMapPkg;

    // Bus and storage widths
    typedef logic [31:0] addrT;
    typedef logic [31:0] wordT;
    typedef logic [7:0]  wordIndexT;
    typedef logic [5:0]  bankOffsetT;
    typedef logic [1:0]  bankSelT;

    // Segment a sits in bit 0
    typedef logic [6:0]  segT;

    typedef logic [17:0] displayT;
    typedef logic [21:0] tubeT;
    typedef logic [7:0]  ledT;

    // Where a read is served from
    typedef enum logic [1:0] {
        regionRam,
        regionTable,
        regionSwitch
    } regionT;

    // RAM organisation
    localparam int numBanks  = 4;
    localparam int bankDepth = 64;

    // Peripheral registers
    localparam addrT ledAddr    = 32'h4000_000C;
    localparam addrT switchAddr = 32'h4000_0010;
    localparam addrT tubeAddr   = 32'h4000_0014;

    // Digit pattern window, one word per index
    localparam addrT tableBase = 32'd1024;
    localparam addrT tableLast = 32'd2044;

    // Display starts fully lit
    localparam displayT displayResetValue = 18'h3_FFFF;

endpackage

// ==== hdl/memoryBank.sv ====
`timescale 1ns/1ps

module memoryBank (
    input  logic     Uart_send_trigger,
    input  logic     clk,
    bankPortIf.bank  bankPort
);

    memMapPkg::wordT mem [memMapPkg::bankDepth];

    // Whole bank clears on reset
    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            for (int i = 0; i < memMapPkg::bankDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (bankPort.writeStrobe) begin
            mem[bankPort.offset] <= bankPort.writeData;
        end
    end

    // Combinational read
    assign bankPort.readWord = mem[bankPort.offset];

    // Decoder must hand over a clean offset with every strobe
    offsetKnownOnWrite: assert property (
        @(posedge Uart_send_trigger) disable iff (clk)
        bankPort.writeStrobe |-> !$isunknown(bankPort.offset)
    ) else $error("memoryBank: unknown offset on write");

endmodule

// ==== hdl/outputRegs.sv ====
`timescale 1ns/1ps

module outputRegs (
    input  logic             Uart_send_trigger,
    input  logic             clk,
    input  logic             ledWrite,
    input  logic             tubeWrite,
    input  memMapPkg::wordT  writeData,
    output memMapPkg::ledT   led,
    output memMapPkg::tubeT  tube
);

    memMapPkg::ledT     ledReg;
    memMapPkg::displayT displayReg;

    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            ledReg <= '0;
        end else if (ledWrite) begin
            ledReg <= writeData[7:0];
        end
    end

    always_ff @(posedge Uart_send_trigger or posedge clk) begin
        if (clk) begin
            displayReg <= memMapPkg::displayResetValue;
        end else if (tubeWrite) begin
            displayReg <= writeData[17:0];
        end
    end

    assign led = ledReg;

    // Top four tube bits mirror display bits 10 to 7
    assign tube = {displayReg[10:7], displayReg};

    // Two distinct addresses, so never both in one cycle
    singleRegWrite: assert property (
        @(posedge Uart_send_trigger) disable iff (clk)
        !(ledWrite && tubeWrite)
    ) else $error("outputRegs: LED and tube written together");

endmodule

// ==== hdl/readMux.sv ====
`timescale 1ns/1ps

module readMux (
    input  logic                readEnable,
    input  memMapPkg::regionT   region,
    input  memMapPkg::bankSelT  bankSel,
    bankPortIf.reader           banks [memMapPkg::numBanks],
    input  memMapPkg::ledT      switches,
    input  memMapPkg::segT      hundreds,
    input  memMapPkg::segT      tens,
    input  memMapPkg::segT      ones,
    output memMapPkg::wordT     readData
);

    memMapPkg::wordT bankWords [memMapPkg::numBanks];

    // Interface arrays need constant indices, so flatten first
    for (genvar g = 0; g < memMapPkg::numBanks; g++) begin : genBankWords
        assign bankWords[g] = banks[g].readWord;
    end

    always_comb begin
        if (!readEnable) begin
            readData = '0;
        end else begin
            case (region)
                memMapPkg::regionSwitch: begin
                    readData = memMapPkg::wordT'(switches);
                end
                memMapPkg::regionTable: begin
                    readData = {11'b0, hundreds, tens, ones};
                end
                default: begin
                    readData = bankWords[bankSel];
                end
            endcase
        end
    end

endmodule

// ==== hdl/segmentTable.sv ====
`timescale 1ns/1ps

module segmentTable (
    input  memMapPkg::wordIndexT index,
    output memMapPkg::segT       hundreds,
    output memMapPkg::segT       tens,
    output memMapPkg::segT       ones
);

    logic [3:0] hundredsDigit;
    logic [3:0] tensDigit;
    logic [3:0] onesDigit;

    // Common cathode, segment a in bit 0
    function automatic memMapPkg::segT digitToSeg(input logic [3:0] digit);
        memMapPkg::segT seg;
        case (digit)
            4'd0:    seg = 7'h3F;
            4'd1:    seg = 7'h06;
            4'd2:    seg = 7'h5B;
            4'd3:    seg = 7'h4F;
            4'd4:    seg = 7'h66;
            4'd5:    seg = 7'h6D;
            4'd6:    seg = 7'h7D;
            4'd7:    seg = 7'h07;
            4'd8:    seg = 7'h7F;
            4'd9:    seg = 7'h6F;
            default: seg = 7'h00;
        endcase
        return seg;
    endfunction

    // Decimal split of 0..255
    assign hundredsDigit = 4'(index / 8'd100);
    assign tensDigit     = 4'((index / 8'd10) % 8'd10);
    assign onesDigit     = 4'(index % 8'd10);

    assign hundreds = digitToSeg(hundredsDigit);
    assign tens     = digitToSeg(tensDigit);
    assign ones     = digitToSeg(onesDigit);

endmodule

// ==== testbench/dataMemoryGolden.txt ====
# op address writeData switches expected, all hex
# W write, R read, I read with enable low, L check led, T check tube; "test" names a group
test resetState
T 00000000 00000000 00 003fffff
L 00000000 00000000 00 00000000
R 00000000 00000000 00 00000000
R 000001fc 00000000 00 00000000
R 000003fc 00000000 00 00000000
R 00000800 00000000 00 00000000
test ramBanks
W 00000004 11111111 00 00000000
W 00000104 22222222 00 00000000
W 00000204 33333333 00 00000000
W 00000304 44444444 00 00000000
R 00000004 00000000 00 11111111
R 00000104 00000000 00 22222222
R 00000204 00000000 00 33333333
R 00000304 00000000 00 44444444
test ramAlias
W 10000c04 aaaa5555 00 00000000
R 00000004 00000000 00 aaaa5555
R 10000c04 00000000 00 aaaa5555
R 00000104 00000000 00 22222222
test tableWindow
R 00000400 00000000 00 000fdfbf
R 00000404 00000000 00 000fdf86
R 00000500 00000000 00 000ffee6
R 00000588 00000000 00 000ff7ff
R 000005ec 00000000 00 0001adcf
R 000007fc 00000000 00 0016f6ed
test tableAlias
W 000001ec 5a5a5a5a 00 00000000
R 000005ec 00000000 00 0001adcf
R 000001ec 00000000 00 5a5a5a5a
W 000005ec 0f0f0f0f 00 00000000
R 000005ec 00000000 00 0001adcf
R 000001ec 00000000 00 0f0f0f0f
test switchRead
R 40000010 00000000 a5 000000a5
I 40000010 00000000 a5 00000000
R 40000010 00000000 3c 0000003c
I 00000004 00000000 00 00000000
test outputRegs
W 0000000c 0c0c0c0c 00 00000000
W 00000014 14141414 00 00000000
W 4000000c deadbeef 00 00000000
L 00000000 00000000 00 000000ef
T 00000000 00000000 00 003fffff
W 40000014 00012345 00 00000000
T 00000000 00000000 00 00192345
L 00000000 00000000 00 000000ef
W 40000014 fffc0780 00 00000000
T 00000000 00000000 00 003c0780
R 0000000c 00000000 00 0c0c0c0c
R 00000014 00000000 00 14141414

// ==== testbench/dataMemoryTb.sv ====
`timescale 1ns/1ps

module dataMemoryTb;

    localparam string goldenPath   = "testbench/dataMemoryGolden.txt";
    localparam int    resetTimeout = 16;

    logic                 Uart_send_trigger;
    logic                 clk;
    logic                 readEnable;
    logic                 writeEnable;
    memMapPkg::addrT      address;
    memMapPkg::wordT      writeData;
    memMapPkg::ledT       switches;
    memMapPkg::ledT       led;
    memMapPkg::tubeT      tube;
    memMapPkg::wordT      readData;

    int    checkCount = 0;
    int    errorCount = 0;
    int    opCount    = 0;
    string testName   = "unnamed";

    dataMemory dut_i (
        .Uart_send_trigger (Uart_send_trigger),
        .clk               (clk),
        .readEnable        (readEnable),
        .writeEnable       (writeEnable),
        .address           (address),
        .writeData         (writeData),
        .switches          (switches),
        .led               (led),
        .tube              (tube),
        .readData          (readData)
    );

    always #10 Uart_send_trigger = ~Uart_send_trigger;

    task automatic checkValue(input string where, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("error: %s expected %h actual %h", where, expected, actual);
        end
    endtask

    // Bus signals for one operation applied on the rising edge
    task automatic driveOp(input string op, input memMapPkg::addrT addr,
                           input memMapPkg::wordT data, input memMapPkg::ledT sw);
        readEnable  <= (op == "R");
        writeEnable <= (op == "W");
        address     <= addr;
        writeData   <= data;
        switches    <= sw;
    endtask

    task automatic waitResetRelease(output bit released);
        int cycles;
        cycles = 0;
        while (clk !== 1'b0 && cycles < resetTimeout) begin
            @(posedge Uart_send_trigger);
            cycles++;
        end
        released = (clk === 1'b0);
    endtask

    task automatic runLine(input string lineText, input int lineNo);
        string           opText;
        string           nameText;
        string           where;
        memMapPkg::addrT addr;
        memMapPkg::wordT data;
        memMapPkg::ledT  sw;
        logic [31:0]     expected;
        int              fields;
        fields = $sscanf(lineText, "%s", opText);
        if (fields < 1 || opText.getc(0) == "#") begin
            return;
        end
        if (opText == "test") begin
            fields = $sscanf(lineText, "%s %s", opText, nameText);
            testName = nameText;
            return;
        end
        fields = $sscanf(lineText, "%s %h %h %h %h", opText, addr, data, sw, expected);
        if (fields != 5) begin
            $display("line %0d of the golden file could not be parsed", lineNo);
            errorCount++;
            return;
        end
        if (opText != "W" && opText != "R" && opText != "I" &&
            opText != "L" && opText != "T") begin
            $display("line %0d of the golden file has an unknown operation %s",
                     lineNo, opText);
            errorCount++;
            return;
        end
        opCount++;
        where = $sformatf("%s line %0d", testName, lineNo);
        @(posedge Uart_send_trigger);
        driveOp(opText, addr, data, sw);
        // Outputs settle well before the falling edge
        @(negedge Uart_send_trigger);
        if (opText == "R" || opText == "I") begin
            checkValue(where, expected, readData);
        end else if (opText == "L") begin
            checkValue(where, expected, {24'b0, led});
        end else if (opText == "T") begin
            checkValue(where, expected, {10'b0, tube});
        end
    endtask

    task automatic playGoldenFile();
        int    fd;
        int    lineNo;
        string lineText;
        fd = $fopen(goldenPath, "r");
        if (fd == 0) begin
            $display("could not open the golden file %s", goldenPath);
            errorCount++;
        end else begin
            lineNo = 0;
            while ($fgets(lineText, fd) != 0) begin
                lineNo++;
                runLine(lineText, lineNo);
            end
            $fclose(fd);
            // Let a trailing write commit, then leave the bus idle
            @(posedge Uart_send_trigger);
            driveOp("I", '0, '0, '0);
            @(posedge Uart_send_trigger);
            if (opCount == 0) begin
                $display("the golden file %s holds no operations", goldenPath);
                errorCount++;
            end
        end
    endtask

    initial begin
        bit resetReleased;
        Uart_send_trigger = 1'b0;
        clk               = 1'b1;
        readEnable        = 1'b0;
        writeEnable       = 1'b0;
        address           = '0;
        writeData         = '0;
        switches          = '0;

        for (int i = 0; i < 4; i++) begin
            @(posedge Uart_send_trigger);
        end
        clk <= 1'b0;
        waitResetRelease(resetReleased);

        if (!resetReleased) begin
            $display("timeout: reset was not released within %0d cycles", resetTimeout);
            $display("tests failed");
        end else begin
            playGoldenFile();
            $display("checks %0d, errors %0d", checkCount, errorCount);
            if (errorCount == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/memMapPkg.sv
hdl/bankPortIf.sv
hdl/addressDecoder.sv
hdl/memoryBank.sv
hdl/outputRegs.sv
hdl/segmentTable.sv
hdl/readMux.sv
hdl/dataMemory.sv
testbench/dataMemoryTb.sv
